// ==== Bender.yml ====
package:
  name: infra

sources:
  - rtl/infra_pkg.sv
  - rtl/rst_sync.sv
  - rtl/rst_sequencer.sv
  - rtl/lock_monitor.sv
  - rtl/ready_watchdog.sv
  - rtl/infra_csr.sv
  - rtl/infra_top.sv
  - target: test
    files:
      - testbench/infra_tb.sv

// ==== compile.f ====
rtl/infra_pkg.sv
rtl/rst_sync.sv
rtl/rst_sequencer.sv
rtl/lock_monitor.sv
rtl/ready_watchdog.sv
rtl/infra_csr.sv
rtl/infra_top.sv
testbench/infra_tb.sv

// ==== rtl/infra_csr.sv ====
`timescale 1ns/1ns
`default_nettype none

module infra_csr (
  input  logic                         sync_clk,
  input  logic                         sync_rst,
  input  logic [infra_pkg::ADDR_W-1:0] paddr,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [infra_pkg::DATA_W-1:0] pwdata,
  output logic [infra_pkg::DATA_W-1:0] prdata,
  output logic                         pready,
  output logic                         pslverr,
  input  logic                         lock,
  input  logic                         periph_rst,
  input  logic                         cal_done,
  input  logic                         cal_timeout,
  input  logic                         lock_lost,
  input  logic [infra_pkg::CNT_W-1:0]  loss_count,
  output logic [infra_pkg::HOLD_W-1:0] hold_len,
  output logic                         restart_pulse,
  output logic                         clear_lost
);

  import infra_pkg::*;

  logic              access;     // First access cycle, the wait state.
  logic              wr_commit;  // Second access cycle of a write.
  logic              sel_ctrl;
  logic              sel_status;
  logic              sel_loss;
  logic              addr_ok;
  logic [DATA_W-1:0] rd_mux;

  assign access    = psel & penable & ~pready;
  assign wr_commit = psel & penable & pready & pwrite;

  assign sel_ctrl   = (paddr == ADDR_CTRL);
  assign sel_status = (paddr == ADDR_STATUS);
  assign sel_loss   = (paddr == ADDR_LOSS);
  assign addr_ok    = sel_ctrl | sel_status | sel_loss;

  // Read mux. soft_restart reads back as zero.
  always_comb begin
    rd_mux = '0;
    if (sel_ctrl) begin
      rd_mux[HOLD_W-1:0] = hold_len;
    end else if (sel_status) begin
      rd_mux[STATUS_CLEAR_BIT:0] = {lock_lost, cal_timeout, cal_done, periph_rst, lock};
    end else if (sel_loss) begin
      rd_mux[CNT_W-1:0] = loss_count;
    end
  end

  always_ff @(posedge sync_clk or posedge sync_rst) begin
    if (sync_rst) begin
      pready        <= 1'b0;
      pslverr       <= 1'b0;
      hold_len      <= HOLD_DEFAULT;
      restart_pulse <= 1'b0;
      clear_lost    <= 1'b0;
    end else begin
      pready  <= access;             // One wait state.
      pslverr <= access & ~addr_ok;  // Unmapped address.
      restart_pulse <= wr_commit & sel_ctrl & pwdata[CTRL_RESTART_BIT];
      clear_lost    <= wr_commit & sel_status & pwdata[STATUS_CLEAR_BIT];
      if (wr_commit && sel_ctrl) begin
        hold_len <= pwdata[HOLD_W-1:0];
      end
    end
  end

  // Read data is captured in the wait state and held through pready.
  always_ff @(posedge sync_clk) begin
    if (access) begin
      prdata <= rd_mux;
    end
  end

  // The slave only completes a transfer the master is still presenting.
  a_pready_in_access: assert property (
    @(posedge sync_clk) disable iff (sync_rst)
    pready |-> (psel && penable)
  );

endmodule

`default_nettype wire

// ==== rtl/infra_pkg.sv ====
`default_nettype none

package infra_pkg;

  // APB port geometry.
  localparam int unsigned ADDR_W = 4;
  localparam int unsigned DATA_W = 32;

  // Reset sequencing.
  localparam int unsigned HOLD_W = 16;                          // Hold field and counter.
  localparam logic [HOLD_W-1:0] HOLD_DEFAULT = HOLD_W'(16);     // Pulse length out of reset.
  localparam int unsigned SYNC_STAGES = 4;                      // Release delay of domain_rst.

  // Monitoring.
  localparam int unsigned CNT_W = 8;                            // Saturates at 255.
  localparam int unsigned READY_TIMEOUT = 64;                   // Cycles allowed for dly_rdy.

  // Register map, byte addresses.
  localparam logic [ADDR_W-1:0] ADDR_CTRL   = 4'h0;
  localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h4;
  localparam logic [ADDR_W-1:0] ADDR_LOSS   = 4'h8;

  // Write-only fields.
  localparam int unsigned CTRL_RESTART_BIT = 31;                // Soft restart, self clearing.
  localparam int unsigned STATUS_CLEAR_BIT = 4;                 // Write 1 clears lock_lost.

endpackage

`default_nettype wire

// ==== rtl/infra_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module infra_top (
  input  logic                         sync_clk,
  input  logic                         sync_rst,
  input  logic                         lock,
  input  logic                         dly_rdy,
  input  logic [infra_pkg::ADDR_W-1:0] paddr,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [infra_pkg::DATA_W-1:0] pwdata,
  output logic [infra_pkg::DATA_W-1:0] prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         domain_rst,
  output logic                         periph_rst,
  output logic                         cal_done,
  output logic                         cal_timeout
);

  import infra_pkg::*;

  logic [HOLD_W-1:0] hold_len;
  logic              restart_pulse;
  logic              clear_lost;
  logic              lock_lost;
  logic [CNT_W-1:0]  loss_count;

  rst_sync #(
    .STAGES(SYNC_STAGES)
  ) u_rst_sync (
    .sync_clk  (sync_clk),
    .sync_rst  (sync_rst),
    .lock      (lock),
    .domain_rst(domain_rst)
  );

  rst_sequencer u_rst_sequencer (
    .sync_clk     (sync_clk),
    .sync_rst     (sync_rst),
    .lock         (lock),
    .hold_len     (hold_len),
    .restart_pulse(restart_pulse),
    .periph_rst   (periph_rst)
  );

  lock_monitor u_lock_monitor (
    .sync_clk  (sync_clk),
    .sync_rst  (sync_rst),
    .lock      (lock),
    .clear_lost(clear_lost),
    .lock_lost (lock_lost),
    .loss_count(loss_count)
  );

  ready_watchdog u_ready_watchdog (
    .sync_clk   (sync_clk),
    .sync_rst   (sync_rst),
    .periph_rst (periph_rst),
    .dly_rdy    (dly_rdy),
    .cal_done   (cal_done),
    .cal_timeout(cal_timeout)
  );

  infra_csr u_infra_csr (
    .sync_clk     (sync_clk),
    .sync_rst     (sync_rst),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .lock         (lock),
    .periph_rst   (periph_rst),
    .cal_done     (cal_done),
    .cal_timeout  (cal_timeout),
    .lock_lost    (lock_lost),
    .loss_count   (loss_count),
    .hold_len     (hold_len),
    .restart_pulse(restart_pulse),
    .clear_lost   (clear_lost)
  );

endmodule

`default_nettype wire

// ==== rtl/lock_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module lock_monitor (
  input  logic                        sync_clk,
  input  logic                        sync_rst,
  input  logic                        lock,
  input  logic                        clear_lost,
  output logic                        lock_lost,
  output logic [infra_pkg::CNT_W-1:0] loss_count
);

  import infra_pkg::*;

  logic lock_q;
  logic lock_fall;

  assign lock_fall = lock_q & ~lock;  // Falling edge of lock.

  always_ff @(posedge sync_clk or posedge sync_rst) begin
    if (sync_rst) begin
      lock_q     <= 1'b0;
      lock_lost  <= 1'b0;
      loss_count <= '0;
    end else begin
      lock_q <= lock;
      if (lock_fall) begin
        lock_lost <= 1'b1;  // A new loss wins over a clear.
      end else if (clear_lost) begin
        lock_lost <= 1'b0;
      end
      if (lock_fall && loss_count != {CNT_W{1'b1}}) begin
        loss_count <= loss_count + 1'b1;  // Saturating.
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ready_watchdog.sv ====
`timescale 1ns/1ns
`default_nettype none

module ready_watchdog (
  input  logic sync_clk,
  input  logic sync_rst,
  input  logic periph_rst,
  input  logic dly_rdy,
  output logic cal_done,
  output logic cal_timeout
);

  import infra_pkg::*;

  logic                               armed;
  logic [$clog2(READY_TIMEOUT)-1:0]   wait_cnt;

  always_ff @(posedge sync_clk or posedge sync_rst) begin
    if (sync_rst) begin
      armed       <= 1'b0;
      wait_cnt    <= '0;
      cal_done    <= 1'b0;
      cal_timeout <= 1'b0;
    end else if (periph_rst) begin
      armed       <= 1'b1;  // Restart the wait on every reset pulse.
      wait_cnt    <= '0;
      cal_done    <= 1'b0;
      cal_timeout <= 1'b0;
    end else if (armed) begin
      if (dly_rdy) begin
        cal_done <= 1'b1;  // Ready beats a timeout on the same edge.
        armed    <= 1'b0;
      end else if (wait_cnt == READY_TIMEOUT - 1) begin
        cal_timeout <= 1'b1;
        armed       <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // Only one verdict per wait.
  a_one_verdict: assert property (
    @(posedge sync_clk) disable iff (sync_rst)
    !(cal_done && cal_timeout)
  );

endmodule

`default_nettype wire

// ==== rtl/rst_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module rst_sequencer (
  input  logic                         sync_clk,
  input  logic                         sync_rst,
  input  logic                         lock,
  input  logic [infra_pkg::HOLD_W-1:0] hold_len,
  input  logic                         restart_pulse,
  output logic                         periph_rst
);

  import infra_pkg::*;

  logic              lock_q;
  logic              active;
  logic [HOLD_W-1:0] hold_cnt;
  logic              start;

  assign start = (lock & ~lock_q) | restart_pulse;  // Lock rise or soft restart.

  always_ff @(posedge sync_clk or posedge sync_rst) begin
    if (sync_rst) begin
      lock_q   <= 1'b0;
      active   <= 1'b0;
      hold_cnt <= '0;
    end else begin
      lock_q <= lock;
      if (!lock) begin
        active   <= 1'b0;  // Lock loss aborts the pulse.
        hold_cnt <= '0;
      end else if (start) begin
        active   <= (hold_len != '0);  // Zero length means no pulse.
        hold_cnt <= HOLD_W'(1);
      end else if (active) begin
        if (hold_cnt >= hold_len) begin
          active <= 1'b0;  // Length reached.
        end else begin
          hold_cnt <= hold_cnt + 1'b1;
        end
      end
    end
  end

  // Gated by lock, as the MMCM may drop at any time.
  assign periph_rst = active & lock;

  // No pulse unless lock holds now and held on the edge before.
  a_no_rst_without_lock: assert property (
    @(posedge sync_clk) disable iff (sync_rst)
    !(lock && lock_q) |-> !periph_rst
  );

endmodule

`default_nettype wire

// ==== rtl/rst_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

module rst_sync #(
  parameter int unsigned STAGES = infra_pkg::SYNC_STAGES
) (
  input  logic sync_clk,
  input  logic sync_rst,
  input  logic lock,
  output logic domain_rst
);

  logic              async_rst;
  logic [STAGES-1:0] sync_reg;

  assign async_rst = sync_rst | ~lock;  // Either source holds the domain.

  // Asserts at once, releases after STAGES clean edges.
  always_ff @(posedge sync_clk or posedge async_rst) begin
    if (async_rst) begin
      sync_reg <= '1;
    end else begin
      sync_reg <= sync_reg << 1;  // Shift zeros toward the output.
    end
  end

  assign domain_rst = sync_reg[STAGES-1];

endmodule

`default_nettype wire

// ==== testbench/infra_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module infra_tb;

  import infra_pkg::*;

  localparam int OP_WRITE   = 0;  // Expected value is pslverr.
  localparam int OP_READ    = 1;
  localparam int OP_LOCK    = 2;
  localparam int OP_RDY     = 3;
  localparam int OP_WAIT    = 4;  // Address field holds the cycle count.
  localparam int OP_MEASURE = 5;  // Address field selects the quantity.

  localparam int M_PULSE      = 0;  // Last periph_rst pulse length.
  localparam int M_DRST_DELAY = 1;  // Lock rise to domain_rst release.
  localparam int M_TMO_DELAY  = 2;  // periph_rst fall to cal_timeout.
  localparam int M_PRST_LEVEL = 3;
  localparam int M_DRST_LEVEL = 4;
  localparam int M_DONE_LEVEL = 5;

  localparam int MAX_STEPS = 48;

  logic              sync_clk;
  logic              sync_rst;
  logic              lock;
  logic              dly_rdy;
  logic [ADDR_W-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              domain_rst;
  logic              periph_rst;
  logic              cal_done;
  logic              cal_timeout;

  int          step_op   [MAX_STEPS];
  logic [31:0] step_addr [MAX_STEPS];
  logic [31:0] step_data [MAX_STEPS];
  logic [31:0] step_exp  [MAX_STEPS];
  string       step_name [MAX_STEPS];
  int          n_steps;

  int     cyc;
  int     cycle_limit;
  int     pass_cnt;
  int     fail_cnt;
  integer seed;

  int   run_len;
  int   last_pulse;
  int   lock_rise_cyc;
  int   drst_delay;
  int   prst_fall_cyc;
  int   tmo_delay;
  logic prst_q;
  logic drst_q;
  logic tmo_q;

  infra_top u_infra_top (
    .sync_clk   (sync_clk),
    .sync_rst   (sync_rst),
    .lock       (lock),
    .dly_rdy    (dly_rdy),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .domain_rst (domain_rst),
    .periph_rst (periph_rst),
    .cal_done   (cal_done),
    .cal_timeout(cal_timeout)
  );

  always #2 sync_clk = ~sync_clk;

  always @(posedge sync_clk) begin
    cyc <= cyc + 1;
  end

  // Pulse and delay measurements, taken mid-cycle.
  always @(negedge sync_clk) begin
    if (periph_rst === 1'b1) begin
      run_len <= run_len + 1;
    end else if (run_len > 0) begin
      last_pulse <= run_len;  // Pulse just ended.
      run_len    <= 0;
    end
    if (prst_q && periph_rst === 1'b0) begin
      prst_fall_cyc <= cyc;
    end
    if (drst_q && domain_rst === 1'b0) begin
      drst_delay <= cyc - lock_rise_cyc;
    end
    if (!tmo_q && cal_timeout === 1'b1) begin
      tmo_delay <= cyc - prst_fall_cyc;
    end
    prst_q <= (periph_rst === 1'b1);
    drst_q <= (domain_rst === 1'b1);
    tmo_q  <= (cal_timeout === 1'b1);
  end

  // Run limit, worked out from the table.
  initial begin
    wait (cycle_limit > 0);
    wait (cyc >= cycle_limit);
    $display("Timeout: run still busy after %0d cycles, stopped.", cyc);
    $display(">>> FAIL");
    $finish;
  end

  task automatic next_cycle;
    @(posedge sync_clk);
    #1;  // Drive just after the edge.
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output logic err, output int waits);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    next_cycle();  // Setup phase.
    penable = 1'b1;
    waits   = 0;
    while (!pready) begin
      next_cycle();
      waits++;
    end
    err = pslverr;
    next_cycle();  // Write lands on this edge.
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err, output int waits);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    next_cycle();
    penable = 1'b1;
    waits   = 0;
    while (!pready) begin
      next_cycle();
      waits++;
    end
    data = prdata;
    err  = pslverr;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
      fail_cnt++;
    end else begin
      $display("[ ok ] %s = %0h", name, actual);
      pass_cnt++;
    end
  endtask

  task automatic measure(input int sel, output logic [31:0] value);
    case (sel)
      M_PULSE:      value = last_pulse;
      M_DRST_DELAY: value = drst_delay;
      M_TMO_DELAY:  value = tmo_delay;
      default: begin
        @(negedge sync_clk);
        if (sel == M_PRST_LEVEL) begin
          value = periph_rst;
        end else if (sel == M_DONE_LEVEL) begin
          value = cal_done;
        end else begin
          value = domain_rst;
        end
        next_cycle();
      end
    endcase
  endtask

  task automatic add_step(input int op, input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] expected, input string name);
    step_op[n_steps]   = op;
    step_addr[n_steps] = addr;
    step_data[n_steps] = data;
    step_exp[n_steps]  = expected;
    step_name[n_steps] = name;
    n_steps++;
  endtask

  task automatic run_step(input int i);
    logic [31:0] value;
    logic        err;
    int          waits;
    case (step_op[i])
      OP_WRITE: begin
        apb_write(step_addr[i][ADDR_W-1:0], step_data[i], err, waits);
        check(step_name[i], step_exp[i], {31'b0, err});
        check({step_name[i], " wait states"}, 1, waits);
      end
      OP_READ: begin
        apb_read(step_addr[i][ADDR_W-1:0], value, err, waits);
        check(step_name[i], step_exp[i], value);
        check({step_name[i], " wait states"}, 1, waits);
      end
      OP_LOCK: begin
        if (!lock && step_data[i][0]) begin
          lock_rise_cyc = cyc;
        end
        lock = step_data[i][0];
      end
      OP_RDY: begin
        dly_rdy = step_data[i][0];
      end
      OP_WAIT: begin
        repeat (step_addr[i]) next_cycle();
      end
      default: begin
        measure(step_addr[i], value);
        check(step_name[i], step_exp[i], value);
      end
    endcase
  endtask

  initial begin : main
    logic [15:0] hl;
    logic [31:0] restart;
    int          wait_sum;
    int          apb_steps;
    sync_clk = 1'b0;
    sync_rst = 1'b1;
    lock     = 1'b0;
    dly_rdy  = 1'b0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    cyc         = 0;
    cycle_limit = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    n_steps     = 0;
    run_len     = 0;
    last_pulse  = 0;
    drst_delay  = 0;
    tmo_delay   = 0;
    prst_fall_cyc = 0;
    lock_rise_cyc = 0;
    prst_q = 1'b0;
    drst_q = 1'b1;
    tmo_q  = 1'b0;
    seed = 32'h8a09ab8f;
    hl = 16'(1 + {$random(seed)} % 40);  // Hold length 1 to 40.
    restart = (32'h1 << CTRL_RESTART_BIT) | {16'h0, hl};

    add_step(OP_READ,    ADDR_CTRL,    0, HOLD_DEFAULT,   "ctrl reset value");
    add_step(OP_READ,    ADDR_STATUS,  0, 0,              "status reset value");
    add_step(OP_READ,    ADDR_LOSS,    0, 0,              "loss reset value");
    add_step(OP_MEASURE, M_DRST_LEVEL, 0, 1,              "domain_rst held in reset");
    add_step(OP_WRITE,   ADDR_CTRL,    {16'h0, hl}, 0,    "write hold_len");
    add_step(OP_READ,    ADDR_CTRL,    0, {16'h0, hl},    "read back hold_len");
    add_step(OP_LOCK,    0,            1, 0,              "raise lock");
    add_step(OP_WAIT,    hl + 6,       0, 0,              "wait for pulse");
    add_step(OP_MEASURE, M_PULSE,      0, hl,             "pulse after lock");
    add_step(OP_MEASURE, M_DRST_DELAY, 0, SYNC_STAGES,    "domain_rst release delay");
    add_step(OP_RDY,     0,            1, 0,              "raise dly_rdy");
    add_step(OP_WAIT,    2,            0, 0,              "wait for cal_done");
    add_step(OP_READ,    ADDR_STATUS,  0, 32'h05,         "status cal_done");
    add_step(OP_MEASURE, M_DONE_LEVEL, 0, 1,              "cal_done output high");
    add_step(OP_RDY,     0,            0, 0,              "drop dly_rdy");
    add_step(OP_WRITE,   ADDR_CTRL,    restart, 0,        "soft restart");
    add_step(OP_WAIT,    hl + READY_TIMEOUT + 8, 0, 0,    "wait for timeout");
    add_step(OP_MEASURE, M_PULSE,      0, hl,             "pulse after restart");
    add_step(OP_MEASURE, M_TMO_DELAY,  0, READY_TIMEOUT,  "timeout delay");
    add_step(OP_READ,    ADDR_STATUS,  0, 32'h09,         "status cal_timeout");
    add_step(OP_MEASURE, M_DONE_LEVEL, 0, 0,              "cal_done output low");
    add_step(OP_WRITE,   ADDR_CTRL,    (32'h1 << CTRL_RESTART_BIT) | 40, 0, "long restart");
    add_step(OP_WAIT,    2,            0, 0,              "enter pulse");
    add_step(OP_MEASURE, M_PRST_LEVEL, 0, 1,              "periph_rst in pulse");
    add_step(OP_LOCK,    0,            0, 0,              "drop lock");
    add_step(OP_MEASURE, M_PRST_LEVEL, 0, 0,              "periph_rst cut by lock loss");
    add_step(OP_MEASURE, M_DRST_LEVEL, 0, 1,              "domain_rst on lock loss");
    add_step(OP_READ,    ADDR_LOSS,    0, 1,              "loss count one");
    add_step(OP_READ,    ADDR_STATUS,  0, 32'h10,         "status lock_lost");
    add_step(OP_WRITE,   ADDR_STATUS,  32'h10, 0,         "clear lock_lost");
    add_step(OP_READ,    ADDR_STATUS,  0, 32'h00,         "status lock_lost cleared");
    add_step(OP_LOCK,    0,            1, 0,              "relock");
    add_step(OP_WAIT,    48,           0, 0,              "wait for long pulse");
    add_step(OP_MEASURE, M_PULSE,      0, 40,             "pulse after relock");
    add_step(OP_MEASURE, M_DRST_DELAY, 0, SYNC_STAGES,    "domain_rst release on relock");
    add_step(OP_WRITE,   ADDR_CTRL,    restart, 0,        "restart with lock high");
    add_step(OP_WAIT,    hl + 4,       0, 0,              "wait for repeat pulse");
    add_step(OP_MEASURE, M_PULSE,      0, hl,             "repeat pulse");
    add_step(OP_WRITE,   4'hC,         32'hffff_ffff, 1,  "unmapped write error");
    add_step(OP_READ,    ADDR_CTRL,    0, {16'h0, hl},    "ctrl unchanged");
    add_step(OP_READ,    ADDR_STATUS,  0, 32'h01,         "status unchanged");
    add_step(OP_READ,    ADDR_LOSS,    0, 1,              "loss unchanged");

    wait_sum  = 0;
    apb_steps = 0;
    for (int i = 0; i < n_steps; i++) begin
      if (step_op[i] == OP_WAIT) begin
        wait_sum += step_addr[i];
      end else if (step_op[i] == OP_WRITE || step_op[i] == OP_READ) begin
        apb_steps++;
      end
    end
    cycle_limit = 3 * wait_sum + 4 * apb_steps;

    repeat (3) @(posedge sync_clk);
    #1;
    sync_rst = 1'b0;

    for (int i = 0; i < n_steps; i++) begin
      run_step(i);
    end

    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
